//--- matvec3.f
matvec_dims_pkg.sv
matvec_ctrl_pkg.sv
operand_bus_if.sv
operand_store.sv
mac_unit.sv
matvec_sequencer.sv
matvec3.sv
matvec3_checker.sv
tb_matvec3.sv

//--- run_sim.sh
#!/bin/sh
# compile the testbench with Verilator, run it and search the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_matvec3 \
    -f matvec3.f -o sim_matvec3 > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_matvec3 > sim.log 2>&1
cat sim.log

grep -q ">>> FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

//--- tb_matvec3.sv
// ######################################
// matrix vector unit testbench
// ######################################

`timescale 1ns/1ps

module tb_matvec3;
    import matvec_dims_pkg::*;

    localparam int RANDOM_JOBS = 12;
    localparam int STALL_JOBS  = 20;
    localparam int MAX_JOBS    = 40;

    // input gaps, result stalls and row compute time per job, plus margin
    localparam int TIMEOUT_CYCLES = MAX_JOBS * JOB_WORDS * 4 + MAX_JOBS * MAT_DIM * 4
                                  + MAX_JOBS * MAT_DIM * 8 + 500;

    localparam int JOB_RANDOM    = 0;
    localparam int JOB_ALL_MIN   = 1;
    localparam int JOB_ALL_MAX   = 2;
    localparam int JOB_ALTERNATE = 3;

    logic    clk;
    logic    reset;
    logic    input_valid;
    logic    input_ready;
    sample_t input_data;
    logic    output_valid;
    logic    output_ready;
    acc_t    output_data;

    integer  seed;
    int      cycles;
    sample_t job_words [JOB_WORDS];   // nine matrix words, then the vector
    acc_t    expected_q [$];

    matvec3 matvec3_i (
        .clk          (clk),
        .reset        (reset),
        .input_valid  (input_valid),
        .input_ready  (input_ready),
        .input_data   (input_data),
        .output_valid (output_valid),
        .output_ready (output_ready),
        .output_data  (output_data)
    );

    bind matvec3 matvec3_checker matvec3_checker_i (
        .clk          (clk),
        .reset        (reset),
        .input_ready  (input_ready),
        .output_valid (output_valid),
        .output_ready (output_ready),
        .output_data  (output_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles <= TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $fatal(1, "timeout");
    end

    task automatic check_result(input string name, input acc_t actual, input acc_t expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "handshake mismatch");
        end
    endtask

    task automatic make_job(input int kind);
        for (int i = 0; i < JOB_WORDS; i++) begin
            case (kind)
                JOB_ALL_MIN:   job_words[i] = sample_t'(-8192);
                JOB_ALL_MAX:   job_words[i] = sample_t'(8191);
                JOB_ALTERNATE: job_words[i] = (i % 2 == 1) ? sample_t'(-8192) : sample_t'(8191);
                default:       job_words[i] = sample_t'($random(seed));
            endcase
        end
    endtask

    // the result port is 28 bits wide, so the expected value keeps the low 28 bits
    function automatic void compute_expected();
        int sum;
        for (int r = 0; r < MAT_DIM; r++) begin
            sum = 0;
            for (int k = 0; k < MAT_DIM; k++) begin
                sum = sum + int'(job_words[r * MAT_DIM + k]) * int'(job_words[MAT_WORDS + k]);
            end
            expected_q.push_back(acc_t'(sum));
        end
    endfunction

    // loads one job and collects its three results
    // with stall set output_ready is random while the results come out
    task automatic run_job(input bit stall);
        int   idx;
        int   row;
        bit   held;
        acc_t held_data;
        acc_t expected;
        idx       = 0;
        row       = 0;
        held      = 1'b0;
        held_data = '0;
        compute_expected();
        while (idx < JOB_WORDS) begin
            @(posedge clk);
            #2;
            input_valid  = ($random(seed) & 3) != 0;   // roughly one cycle in four is a gap
            input_data   = job_words[idx];
            output_ready = stall ? (($random(seed) & 1) != 0) : 1'b1;
            @(negedge clk);
            check_flag("input_ready", input_ready, 1'b1);
            check_flag("output_valid", output_valid, 1'b0);
            if (input_valid && input_ready) begin
                idx++;
            end
        end
        while (row < MAT_DIM) begin
            @(posedge clk);
            #2;
            // stray words here must never be taken
            input_valid  = ($random(seed) & 1) != 0;
            input_data   = sample_t'($random(seed));
            output_ready = stall ? (($random(seed) & 1) != 0) : 1'b1;
            @(negedge clk);
            check_flag("input_ready", input_ready, 1'b0);
            if (held) begin
                check_flag("output_valid", output_valid, 1'b1);
                check_result("output_data", output_data, held_data);
            end
            held      = output_valid && !output_ready;
            held_data = output_data;
            if (output_valid && output_ready) begin
                expected = expected_q.pop_front();
                check_result("output_data", output_data, expected);
                row++;
            end
        end
        @(posedge clk);
        #2;
        input_valid  = 1'b0;
        output_ready = 1'b0;
        @(negedge clk);
        check_flag("input_ready", input_ready, 1'b1);    // ready for the next job
        check_flag("output_valid", output_valid, 1'b0);
    endtask

    initial begin
        seed         = 32'he29c;
        reset        = 1'b1;
        input_valid  = 1'b0;
        input_data   = '0;
        output_ready = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        check_flag("input_ready", input_ready, 1'b1);
        check_flag("output_valid", output_valid, 1'b0);

        for (int j = 0; j < RANDOM_JOBS; j++) begin
            make_job(JOB_RANDOM);
            run_job(1'b0);
        end
        for (int j = 0; j < STALL_JOBS; j++) begin
            make_job(JOB_RANDOM);
            run_job(1'b1);
        end
        // extreme samples, each once without and once with back-pressure
        for (int kind = JOB_ALL_MIN; kind <= JOB_ALTERNATE; kind++) begin
            make_job(kind);
            run_job(1'b0);
            make_job(kind);
            run_job(1'b1);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- matvec3_checker.sv
// ######################################
// handshake assertions
// ######################################

`timescale 1ns/1ps

module matvec3_checker (
    input logic                  clk,
    input logic                  reset,
    input logic                  input_ready,
    input logic                  output_valid,
    input logic                  output_ready,
    input matvec_dims_pkg::acc_t output_data
);

    // a stalled result must not change
    stable_while_stalled: assert property (
        @(posedge clk) disable iff (reset)
        output_valid && !output_ready |=> $stable(output_data)
    ) else $error("output_data changed while output_valid was stalled");

    // the unit either loads or presents, never both
    no_overlap: assert property (
        @(posedge clk) disable iff (reset)
        !(input_ready && output_valid)
    ) else $error("input_ready and output_valid high together");

    valid_held: assert property (
        @(posedge clk) disable iff (reset)
        output_valid && !output_ready |=> output_valid
    ) else $error("output_valid dropped before the result was accepted");   // no result may be lost

endmodule

//--- matvec3.sv
// ######################################
// matrix vector unit top level
// ######################################

`timescale 1ns/1ps

module matvec3 (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     input_valid,
    output logic                     input_ready,
    input  matvec_dims_pkg::sample_t input_data,
    output logic                     output_valid,
    input  logic                     output_ready,
    output matvec_dims_pkg::acc_t    output_data
);
    import matvec_dims_pkg::*;

    sample_t w_operand;
    sample_t x_operand;
    logic    acc_first;
    logic    acc_en;

    // write strobes, addresses and data from the sequencer to the store
    operand_bus_if ops ();

    matvec_sequencer matvec_sequencer_i (
        .clk          (clk),
        .reset        (reset),
        .input_valid  (input_valid),
        .input_ready  (input_ready),
        .input_data   (input_data),
        .output_valid (output_valid),
        .output_ready (output_ready),
        .ops          (ops.sequencer),
        .acc_first    (acc_first),
        .acc_en       (acc_en)
    );

    // the store sits beside the MAC that it feeds
    operand_store operand_store_i (
        .clk       (clk),
        .ops       (ops.store),
        .w_operand (w_operand),
        .x_operand (x_operand)
    );

    mac_unit mac_unit_i (
        .clk       (clk),
        .reset     (reset),
        .w_operand (w_operand),
        .x_operand (x_operand),
        .acc_first (acc_first),
        .acc_en    (acc_en),
        .acc       (output_data)   // the accumulator is the row result
    );

endmodule

//--- matvec_sequencer.sv
// ######################################
// load and compute sequencer
// ######################################

`timescale 1ns/1ps

module matvec_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     input_valid,
    output logic                     input_ready,
    input  matvec_dims_pkg::sample_t input_data,
    output logic                     output_valid,
    input  logic                     output_ready,
    operand_bus_if.sequencer         ops,
    output logic                     acc_first,
    output logic                     acc_en
);
    import matvec_dims_pkg::*;
    import matvec_ctrl_pkg::*;

    seq_state_t  state;
    load_count_t load_count;    // index of the next input word of the job
    logic [1:0]  row;           // row being computed or presented
    x_addr_t     term;          // column of the term being issued

    logic in_fire;
    logic out_fire;
    logic issue;

    // one bit per cycle of read latency, so each term's controls meet its operands
    logic [READ_LATENCY-1:0] en_pipe;
    logic [READ_LATENCY-1:0] first_pipe;
    logic [READ_LATENCY-1:0] last_pipe;

    // both handshakes come straight from the state, so they can never be high together
    assign input_ready  = (state == LOAD);
    assign output_valid = (state == PRESENT);

    assign in_fire  = input_valid && input_ready;
    assign out_fire = output_valid && output_ready;
    assign issue    = (state == ISSUE);

    // words 0 to 8 go to the matrix, words 9 to 11 to the vector
    assign ops.wr_data = input_data;
    assign ops.wr_en_w = in_fire && (load_count < MAT_WORDS);
    assign ops.wr_en_x = in_fire && (load_count >= MAT_WORDS);

    // addresses follow the word count while loading and the row and term otherwise
    always_comb begin
        if (state == LOAD) begin
            ops.addr_w = w_addr_t'(load_count);
            ops.addr_x = x_addr_t'(load_count - load_count_t'(MAT_WORDS));
        end else begin
            ops.addr_w = w_addr_t'(row * MAT_DIM + term);   // row-major element W[row][term]
            ops.addr_x = term;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= LOAD;
            load_count <= '0;
            row        <= '0;
            term       <= '0;
        end else begin
            case (state)
                LOAD: begin
                    if (in_fire) begin
                        if (load_count == load_count_t'(JOB_WORDS - 1)) begin
                            load_count <= '0;
                            state      <= ISSUE;   // input_ready drops with the 12th word
                        end else begin
                            load_count <= load_count + 1'b1;
                        end
                    end
                end

                // one address pair per cycle, the reads overlap the accumulates
                ISSUE: begin
                    if (term == x_addr_t'(MAT_DIM - 1)) begin
                        term  <= '0;
                        state <= DRAIN;
                    end else begin
                        term <= term + 1'b1;
                    end
                end

                // leave once the last term of the row is being accumulated
                DRAIN: begin
                    if (last_pipe[READ_LATENCY-1]) begin
                        state <= PRESENT;
                    end
                end

                PRESENT: begin
                    if (out_fire) begin
                        if (row == 2'(MAT_DIM - 1)) begin
                            row   <= '0;
                            state <= LOAD;         // the whole job is out, take the next one
                        end else begin
                            row   <= row + 1'b1;
                            state <= ISSUE;
                        end
                    end
                end

                default: begin
                    state <= LOAD;
                end
            endcase
        end
    end

    // delay the accumulate controls by the read latency of the store
    always_ff @(posedge clk) begin
        if (reset) begin
            en_pipe    <= '0;
            first_pipe <= '0;
            last_pipe  <= '0;
        end else begin
            en_pipe[0]    <= issue;
            first_pipe[0] <= issue && (term == '0);
            last_pipe[0]  <= issue && (term == x_addr_t'(MAT_DIM - 1));
            for (int i = 1; i < READ_LATENCY; i++) begin
                en_pipe[i]    <= en_pipe[i-1];
                first_pipe[i] <= first_pipe[i-1];
                last_pipe[i]  <= last_pipe[i-1];
            end
        end
    end

    assign acc_en    = en_pipe[READ_LATENCY-1];
    assign acc_first = first_pipe[READ_LATENCY-1];

endmodule

//--- mac_unit.sv
// ######################################
// signed multiply accumulate
// ######################################

`timescale 1ns/1ps

module mac_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  matvec_dims_pkg::sample_t w_operand,
    input  matvec_dims_pkg::sample_t x_operand,
    input  logic                     acc_first,
    input  logic                     acc_en,
    output matvec_dims_pkg::acc_t    acc
);
    import matvec_dims_pkg::*;

    acc_t product;
    acc_t sum;

    // both operands are signed, so they are sign extended to the full
    // 28-bit width before the multiply and the product is exact
    assign product = w_operand * x_operand;

    // a sum of three extreme products can pass the 28-bit range
    // and then keeps only its low 28 bits, like the result port
    assign sum = acc + product;

    // the first term of a row loads the product and drops the previous row,
    // so no clear cycle sits between rows
    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
        end else if (acc_en) begin
            if (acc_first) begin
                acc <= product;
            end else begin
                acc <= sum;
            end
        end
        // without acc_en the result holds, which keeps it stable under back-pressure
    end

endmodule

//--- operand_store.sv
// ######################################
// matrix and vector operand store
// ######################################

`timescale 1ns/1ps

module operand_store (
    input  logic                     clk,
    operand_bus_if.store             ops,
    output matvec_dims_pkg::sample_t w_operand,
    output matvec_dims_pkg::sample_t x_operand
);
    import matvec_dims_pkg::*;

    sample_t mem_w [MAT_WORDS];   // matrix, row-major
    sample_t mem_x [MAT_DIM];     // vector

    // the matrix memory writes on its strobe and reads its address every cycle
    // a read of the address being written returns the old word
    always_ff @(posedge clk) begin
        if (ops.wr_en_w) begin
            mem_w[ops.addr_w] <= ops.wr_data;
        end
        w_operand <= mem_w[ops.addr_w];
    end

    // same for the vector, on its own strobe and address
    always_ff @(posedge clk) begin
        if (ops.wr_en_x) begin
            mem_x[ops.addr_x] <= ops.wr_data;
        end
        x_operand <= mem_x[ops.addr_x];   // one cycle after the address
    end

endmodule

//--- operand_bus_if.sv
// ######################################
// operand store write bus
// ######################################

`timescale 1ns/1ps

interface operand_bus_if;
    import matvec_dims_pkg::*;

    logic    wr_en_w;    // write strobe of the matrix memory
    logic    wr_en_x;    // write strobe of the vector memory
    w_addr_t addr_w;     // write and read address of the matrix
    x_addr_t addr_x;     // write and read address of the vector
    sample_t wr_data;

    // the sequencer owns every signal on the bus
    modport sequencer (
        output wr_en_w,
        output wr_en_x,
        output addr_w,
        output addr_x,
        output wr_data
    );

    modport store (
        input wr_en_w,
        input wr_en_x,
        input addr_w,
        input addr_x,
        input wr_data
    );

endinterface

//--- matvec_ctrl_pkg.sv
// ######################################
// sequencer control definitions
// ######################################

package matvec_ctrl_pkg;

    // LOAD takes the twelve input words, ISSUE walks the three terms of a row,
    // DRAIN waits for the last accumulate and PRESENT offers the row result
    typedef enum logic [1:0] {
        LOAD    = 2'd0,
        ISSUE   = 2'd1,
        DRAIN   = 2'd2,
        PRESENT = 2'd3
    } seq_state_t;

    // cycles from address to read data in the operand store
    localparam int READ_LATENCY = 1;

endpackage

//--- matvec_dims_pkg.sv
// ######################################
// matrix vector sizes and types
// ######################################

package matvec_dims_pkg;

    // a 3x3 matrix times a 3-element vector
    localparam int MAT_DIM   = 3;
    localparam int MAT_WORDS = MAT_DIM * MAT_DIM;
    localparam int JOB_WORDS = MAT_WORDS + MAT_DIM;   // matrix words first, then the vector

    // sample and result widths
    localparam int SAMPLE_W = 14;
    localparam int ACC_W    = 2 * SAMPLE_W;           // a full product fits exactly

    // one signed input word
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // signed product, running sum and result
    typedef logic signed [ACC_W-1:0] acc_t;

    // memory addresses
    typedef logic [3:0] w_addr_t;                     // 0 to 8, row-major
    typedef logic [1:0] x_addr_t;                     // 0 to 2

    // counts the words of one job as they arrive
    typedef logic [3:0] load_count_t;

endpackage
